// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_bch_dec
FILELIST  = sim.f
OBJ_DIR   = obj_dir

SOURCES = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bch_apb_regs.sv
`timescale 1ns/100ps

module bch_apb_regs (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [bch_pkg::apb_addr_w-1:0]      paddr,
	input  logic [bch_pkg::apb_data_w-1:0]      pwdata,
	output logic [bch_pkg::apb_data_w-1:0]      prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  logic                                done_pulse,
	input  logic [bch_pkg::code_n-1:0]          data_out,
	input  logic [bch_pkg::err_cnt_w-1:0]       count_out,
	output logic [bch_pkg::code_n-1:0]          rx_word,
	output logic                                start
);

	bch_pkg::dec_state_e state;
	bch_pkg::bch_op_e    op;
	logic [bch_pkg::code_n-1:0] data_in_q;
	logic wr_acc;
	logic addr_ok;
	logic wr_ctrl;
	logic decode_req;
	logic clear_req;
	logic busy;

	// ======================================================================
	// Access decode
	// ======================================================================
	assign wr_acc  = psel && penable && pwrite;
	assign addr_ok = (paddr == bch_pkg::reg_ctrl) || (paddr == bch_pkg::reg_data_in) ||
		(paddr == bch_pkg::reg_status) || (paddr == bch_pkg::reg_data_out);
	assign op         = bch_pkg::bch_op_e'(pwdata[1:0]);
	assign wr_ctrl    = wr_acc && (paddr == bch_pkg::reg_ctrl);
	assign decode_req = wr_ctrl && (op == bch_pkg::op_decode);
	assign clear_req  = wr_ctrl && (op == bch_pkg::op_clear);
	assign busy = (state == bch_pkg::st_syn) || (state == bch_pkg::st_search);

	assign pready  = 1'b1; // No wait states.
	// A DECODE that arrives mid-decode is dropped and flagged.
	assign pslverr = psel && penable && (!addr_ok || (decode_req && busy));

	always_ff @(posedge clk) begin
		if (wr_acc && paddr == bch_pkg::reg_data_in)
			data_in_q <= pwdata[bch_pkg::code_n-1:0];
	end

	assign rx_word = data_in_q;

	// ======================================================================
	// Decode sequencer
	// ======================================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= bch_pkg::st_idle;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				bch_pkg::st_idle, bch_pkg::st_done: begin
					if (decode_req) begin
						start <= 1'b1;
						state <= bch_pkg::st_syn;
					end else if (clear_req) begin
						state <= bch_pkg::st_idle; // Drops done.
					end
				end
				bch_pkg::st_syn:    state <= bch_pkg::st_search;
				bch_pkg::st_search: if (done_pulse) state <= bch_pkg::st_done;
				default:            state <= bch_pkg::st_idle;
			endcase
		end
	end

	// Read mux.
	always_comb begin
		prdata = '0;
		case (paddr)
			bch_pkg::reg_data_in:  prdata[bch_pkg::code_n-1:0] = data_in_q;
			bch_pkg::reg_status: begin
				prdata[bch_pkg::sts_busy] = busy;
				prdata[bch_pkg::sts_done] = (state == bch_pkg::st_done);
				prdata[bch_pkg::sts_cnt +: bch_pkg::err_cnt_w] = count_out;
				prdata[bch_pkg::sts_unc]  = (count_out == bch_pkg::err_cnt_unc);
			end
			bch_pkg::reg_data_out: prdata[bch_pkg::code_n-1:0] = data_out;
			default: ;
		endcase
	end

	// A result only comes back for the decode in flight.
	a_done_in_search: assert property (@(posedge clk) disable iff (!arst_n)
		done_pulse |-> (state == bch_pkg::st_search));

endmodule

// File: bch_correct.sv
`timescale 1ns/100ps

module bch_correct #(
	parameter int BITS = 1
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             start,
	input  logic [bch_pkg::code_n-1:0]       rx_word,
	input  logic [BITS-1:0]                  err,
	input  logic                             valid,
	input  logic                             last,
	input  logic [bch_pkg::err_cnt_w-1:0]    err_count,
	output logic [bch_pkg::code_n-1:0]       data_out,
	output logic [bch_pkg::err_cnt_w-1:0]    count_out,
	output logic                             done_pulse
);

	localparam int BASE_W = $clog2(bch_pkg::code_n + BITS);

	logic [bch_pkg::code_n-1:0]      word_q;
	logic [BASE_W-1:0]               base_q;
	logic [bch_pkg::code_n+BITS-1:0] err_wide;
	logic [bch_pkg::code_n-1:0]      fixed;

	// Lanes past bit 14 fall off the top.
	assign err_wide = {{bch_pkg::code_n{1'b0}}, err} << base_q;
	assign fixed    = word_q ^ err_wide[bch_pkg::code_n-1:0];

	// ======================================================================
	// Working word and position
	// ======================================================================
	always_ff @(posedge clk) begin
		if (start)
			word_q <= rx_word;
		else if (valid)
			word_q <= fixed;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			base_q <= '0;
		else if (start)
			base_q <= '0;
		else if (valid)
			base_q <= base_q + BASE_W'(BITS); // Next group of positions.
	end

	// Result registers.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_out   <= '0;
			count_out  <= '0;
			done_pulse <= 1'b0;
		end else begin
			done_pulse <= valid && last;
			if (valid && last) begin
				data_out  <= fixed;     // Includes the final lanes.
				count_out <= err_count;
			end
		end
	end

	// Locator output must be quiet between searches.
	a_err_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		!valid |-> (err == '0));

endmodule

// File: bch_dec_top.sv
`timescale 1ns/100ps

module bch_dec_top #(
	parameter int BITS = 1
) (
	input  logic                           clk,
	input  logic                           arst_n,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [bch_pkg::apb_addr_w-1:0] paddr,
	input  logic [bch_pkg::apb_data_w-1:0] pwdata,
	output logic [bch_pkg::apb_data_w-1:0] prdata,
	output logic                           pready,
	output logic                           pslverr
);

	logic [bch_pkg::code_n-1:0]    rx_word;
	logic                          start;
	logic [bch_pkg::gf_m-1:0]      s1;
	logic [bch_pkg::gf_m-1:0]      s3;
	logic                          syn_valid;
	logic [bch_pkg::err_cnt_w-1:0] err_count;
	logic [BITS-1:0]               err;
	logic                          valid;
	logic                          last;
	logic                          done_pulse;
	logic [bch_pkg::code_n-1:0]    data_out;
	logic [bch_pkg::err_cnt_w-1:0] count_out;

	// ======================================================================
	// Decode, execute, result
	// ======================================================================
	bch_apb_regs i_bch_apb_regs (
		.clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.done_pulse, .data_out, .count_out, .rx_word, .start
	);

	bch_syndrome i_bch_syndrome (
		.clk, .arst_n, .start, .rx_word, .s1, .s3, .syn_valid
	);

	// first and ready are not needed; the sequencer blocks overlap.
	bch_error_dec #(.BITS(BITS)) i_bch_error_dec (
		.clk, .arst_n, .syn_valid, .s1, .s3,
		.err_count, .err, .first(), .last, .valid, .ready()
	);

	bch_correct #(.BITS(BITS)) i_bch_correct (
		.clk, .arst_n, .start, .rx_word, .err, .valid, .last, .err_count,
		.data_out, .count_out, .done_pulse
	);

endmodule

// File: bch_error_dec.sv
`timescale 1ns/100ps

module bch_error_dec #(
	parameter int BITS = 1
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             syn_valid,
	input  logic [bch_pkg::gf_m-1:0]         s1,
	input  logic [bch_pkg::gf_m-1:0]         s3,
	output logic [bch_pkg::err_cnt_w-1:0]    err_count,
	output logic [BITS-1:0]                  err,
	output logic                             first,
	output logic                             last,
	output logic                             valid,
	output logic                             ready
);

	localparam int CYCLES   = (bch_pkg::code_n + BITS - 1) / BITS;
	localparam int CYC_W    = $clog2(CYCLES + 1);
	localparam int RUNT_RAW = bch_pkg::code_n % BITS;
	localparam int RUNT     = (RUNT_RAW != 0) ? RUNT_RAW : BITS;
	localparam logic [BITS-1:0] RUNT_MASK = {BITS{1'b1}} >> (BITS - RUNT);

	logic [bch_pkg::gf_m-1:0] s1_q;
	logic [bch_pkg::gf_m-1:0] s3_q;
	logic [bch_pkg::gf_m-1:0] pow1_q;   // alpha^base.
	logic [bch_pkg::gf_m-1:0] pow3_q;   // alpha^(3*base).
	logic [CYC_W-1:0]         cyc;
	logic                     busy;
	logic                     accept;
	logic [BITS-1:0]          lane_err;

	// Error count from S1, S3.
	//   S1 = 0,  S3 = 0       no error
	//   S1 != 0, S3 = S1^3    one error
	//   S1 != 0, S3 != S1^3   two errors
	//   S1 = 0,  S3 != 0      uncorrectable
	function automatic logic [bch_pkg::err_cnt_w-1:0] classify(
			input logic [bch_pkg::gf_m-1:0] a1,
			input logic [bch_pkg::gf_m-1:0] a3);
		logic [bch_pkg::gf_m-1:0] cube;
		cube = bch_pkg::gf_mul(a1, bch_pkg::gf_mul(a1, a1));
		if (a1 != '0)
			return (cube == a3) ? 2'd1 : 2'd2;
		else
			return (a3 != '0) ? bch_pkg::err_cnt_unc : 2'd0;
	endfunction

	assign accept = syn_valid && !busy;

	// ======================================================================
	// Search control
	// ======================================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cyc  <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			cyc  <= '0;
		end else if (busy) begin
			if (cyc == CYC_W'(CYCLES - 1))
				busy <= 1'b0;
			else
				cyc <= cyc + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			s1_q      <= s1;
			s3_q      <= s3;
			err_count <= classify(s1, s3);
			pow1_q    <= 4'b0001;
			pow3_q    <= 4'b0001;
		end else if (busy) begin
			pow1_q <= bch_pkg::gf_mul(pow1_q, bch_pkg::gf_alpha(BITS)); // Step by BITS.
			pow3_q <= bch_pkg::gf_mul(pow3_q, bch_pkg::gf_alpha(3 * BITS));
		end
	end

	// ======================================================================
	// Per-lane trial flip
	// ======================================================================
	for (genvar i = 0; i < BITS; i++) begin : g_lane
		logic [bch_pkg::gf_m-1:0] s1_flip;
		logic [bch_pkg::gf_m-1:0] s3_flip;

		// Flipping bit base+i adds alpha^j to S1 and alpha^3j to S3.
		assign s1_flip = s1_q ^ bch_pkg::gf_mul(pow1_q, bch_pkg::gf_alpha(i));
		assign s3_flip = s3_q ^ bch_pkg::gf_mul(pow3_q, bch_pkg::gf_alpha(3 * i));
		assign lane_err[i] = classify(s1_flip, s3_flip) < err_count; // Count dropped.
	end

	assign valid = busy;
	assign first = busy && (cyc == '0);
	assign last  = busy && (cyc == CYC_W'(CYCLES - 1));
	assign ready = !busy;

	// Nothing to locate for an uncorrectable word.
	assign err = (!valid || err_count == bch_pkg::err_cnt_unc) ? '0 :
		(last ? (lane_err & RUNT_MASK) : lane_err);

	// No back-pressure, so syndromes must not arrive mid-search.
	a_syn_when_ready: assert property (@(posedge clk) disable iff (!arst_n)
		syn_valid |-> ready);

endmodule

// File: bch_pkg.sv
package bch_pkg;

	// ======================================================================
	// Code and field sizes
	// ======================================================================
	localparam int gf_m      = 4;   // Bits per GF(2^4) element.
	localparam int code_n    = 15;  // Codeword length.
	localparam int code_k    = 7;   // Message length.
	localparam int err_cnt_w = 2;

	localparam logic [err_cnt_w-1:0] err_cnt_unc = 2'd3; // More than two errors.

	// Low bits of the primitive polynomial x^4 + x + 1.
	localparam logic [gf_m-1:0] gf_poly = 4'b0011;

	// ======================================================================
	// APB register map
	// ======================================================================
	localparam int apb_addr_w = 4;
	localparam int apb_data_w = 32;

	localparam logic [apb_addr_w-1:0] reg_ctrl     = 4'h0;
	localparam logic [apb_addr_w-1:0] reg_data_in  = 4'h4;
	localparam logic [apb_addr_w-1:0] reg_status   = 4'h8;
	localparam logic [apb_addr_w-1:0] reg_data_out = 4'hC;

	// STATUS bit positions.
	localparam int sts_busy = 0;
	localparam int sts_done = 1;
	localparam int sts_cnt  = 2;    // Two bits, error count.
	localparam int sts_unc  = 4;

	typedef enum logic [1:0] {
		op_nop    = 2'd0,
		op_decode = 2'd1,
		op_clear  = 2'd2
	} bch_op_e;

	typedef enum logic [1:0] {
		st_idle,
		st_syn,
		st_search,
		st_done
	} dec_state_e;

	// Shift and add multiply, reduced modulo the primitive polynomial.
	function automatic logic [gf_m-1:0] gf_mul(input logic [gf_m-1:0] a,
			input logic [gf_m-1:0] b);
		logic [gf_m-1:0] prod;
		logic [gf_m-1:0] x;
		prod = '0;
		x    = a;
		for (int k = 0; k < gf_m; k++) begin
			if (b[k])
				prod = prod ^ x;
			x = {x[gf_m-2:0], 1'b0} ^ (x[gf_m-1] ? gf_poly : '0);
		end
		return prod;
	endfunction

	// Alpha to the power e, exponent taken modulo 15.
	function automatic logic [gf_m-1:0] gf_alpha(input int unsigned e);
		logic [gf_m-1:0] a;
		int unsigned r;
		r = e % code_n;
		a = 4'b0001;
		for (int k = 0; k < code_n - 1; k++) begin
			if (k < r)
				a = {a[gf_m-2:0], 1'b0} ^ (a[gf_m-1] ? gf_poly : '0);
		end
		return a;
	endfunction

endpackage

// File: bch_syndrome.sv
`timescale 1ns/100ps

module bch_syndrome (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic                          start,
	input  logic [bch_pkg::code_n-1:0]    rx_word,
	output logic [bch_pkg::gf_m-1:0]      s1,
	output logic [bch_pkg::gf_m-1:0]      s3,
	output logic                          syn_valid
);

	logic [bch_pkg::gf_m-1:0] s1_next;
	logic [bch_pkg::gf_m-1:0] s3_next;

	// ======================================================================
	// Syndrome evaluation
	// ======================================================================
	// r(alpha) and r(alpha^3). Each set bit j adds alpha^j and alpha^3j.
	always_comb begin
		s1_next = '0;
		s3_next = '0;
		for (int j = 0; j < bch_pkg::code_n; j++) begin
			if (rx_word[j]) begin
				s1_next = s1_next ^ bch_pkg::gf_alpha(j);
				s3_next = s3_next ^ bch_pkg::gf_alpha(3 * j);
			end
		end
	end

	// Word is held stable by the register block; capture on start.
	always_ff @(posedge clk) begin
		if (start) begin
			s1 <= s1_next;
			s3 <= s3_next;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			syn_valid <= 1'b0;
		else
			syn_valid <= start; // One cycle after start.
	end

endmodule

// File: sim.f
+incdir+.
bch_pkg.sv
bch_apb_regs.sv
bch_syndrome.sv
bch_error_dec.sv
bch_correct.sv
bch_dec_top.sv
tb_bch_dec.sv

// File: tb_bch_model.svh
`ifndef TB_BCH_MODEL_SVH
`define TB_BCH_MODEL_SVH

// ======================================================================
// Reference model for the (15,7) BCH code over GF(2^4)
// ======================================================================

// Carry-less product, then reduction by x^4 + x + 1.
function automatic logic [3:0] gf_times(input logic [3:0] a, input logic [3:0] b);
	logic [6:0] p;
	p = '0;
	for (int i = 0; i < 4; i++) begin
		if (b[i])
			p = p ^ (7'(a) << i);
	end
	for (int i = 6; i >= 4; i--) begin
		if (p[i])
			p = p ^ (7'b0010011 << (i - 4));
	end
	return p[3:0];
endfunction

// Alpha is the element x, value 2.
function automatic logic [3:0] power_of_alpha(input int e);
	logic [3:0] a;
	a = 4'h1;
	for (int i = 0; i < e % 15; i++)
		a = gf_times(a, 4'h2);
	return a;
endfunction

// Systematic encoder, g(x) = x^8 + x^7 + x^6 + x^4 + 1.
function automatic logic [14:0] encode_message(input logic [6:0] msg);
	logic [14:0] rem;
	rem = {msg, 8'h00};
	for (int i = 14; i >= 8; i--) begin
		if (rem[i])
			rem = rem ^ (15'h01d1 << (i - 8));
	end
	return {msg, rem[7:0]};
endfunction

// Returns {S3, S1} of a received word.
function automatic logic [7:0] word_syndromes(input logic [14:0] w);
	logic [3:0] s1;
	logic [3:0] s3;
	s1 = '0;
	s3 = '0;
	for (int j = 0; j < 15; j++) begin
		if (w[j]) begin
			s1 = s1 ^ power_of_alpha(j);
			s3 = s3 ^ power_of_alpha(3 * j);
		end
	end
	return {s3, s1};
endfunction

// 0, 1 or 2 errors, 3 when S1 is zero but S3 is not.
function automatic logic [1:0] expected_count(input logic [14:0] w);
	logic [7:0] syn;
	logic [3:0] cube;
	syn  = word_syndromes(w);
	cube = gf_times(syn[3:0], gf_times(syn[3:0], syn[3:0]));
	if (syn[3:0] == 4'h0)
		return (syn[7:4] == 4'h0) ? 2'd0 : 2'd3;
	return (cube == syn[7:4]) ? 2'd1 : 2'd2;
endfunction

`endif

// File: tb_bch_dec.sv
`timescale 1ns/100ps

module tb_bch_dec;

	localparam int bits      = 4;   // Runt lane of 3 in the last cycle.
	localparam int n_clean   = 4;
	localparam int n_double  = 10;
	localparam int num_tests = n_clean + 15 + n_double + 2;
	localparam logic [31:0] cmd_decode = 32'd1;
	localparam logic [31:0] cmd_clear  = 32'd2;

	logic        clk;
	logic        arst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	`include "tb_bch_model.svh"

	bch_dec_top #(.BITS(bits)) i_bch_dec_top (
		.clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr
	);

	always #2 clk = ~clk;

	// ======================================================================
	// APB access and checking
	// ======================================================================
	task automatic check_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected %0h actual %0h", test, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "Mismatch in %s", test);
		end
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		#1 err = pslverr;   // Access phase, before the rising edge.
		check_value("apb write pready", 32'd1, 32'(pready));
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk);
		penable = 1'b1;
		#1;
		data = prdata;
		err  = pslverr;
		check_value("apb read pready", 32'd1, 32'(pready));
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_done(input string test);
		logic [31:0] rd;
		logic        err;
		rd = '0;
		while (!rd[1]) begin
			apb_read(bch_pkg::reg_status, rd, err);
			check_value({test, " status slverr"}, 32'd0, 32'(err));
		end
	endtask

	task automatic start_decode(input string test, input logic [14:0] rx);
		logic err;
		apb_write(bch_pkg::reg_data_in, 32'(rx), err);
		check_value({test, " data_in slverr"}, 32'd0, 32'(err));
		apb_write(bch_pkg::reg_ctrl, cmd_decode, err);
		check_value({test, " decode slverr"}, 32'd0, 32'(err));
	endtask

	// Waits, checks the result registers, then clears done.
	task automatic finish_decode(input string test, input logic [14:0] exp_word,
			input logic [1:0] exp_cnt);
		logic [31:0] rd;
		logic        err;
		wait_done(test);
		apb_read(bch_pkg::reg_data_out, rd, err);
		check_value({test, " data_out"}, 32'(exp_word), rd);
		apb_read(bch_pkg::reg_status, rd, err);
		check_value({test, " busy"}, 32'd0, 32'(rd[0]));
		check_value({test, " count"}, 32'(exp_cnt), 32'(rd[3:2]));
		check_value({test, " unc flag"}, 32'(exp_cnt == 2'd3), 32'(rd[4]));
		apb_write(bch_pkg::reg_ctrl, cmd_clear, err);
	endtask

	task automatic run_decode(input string test, input logic [14:0] rx,
			input logic [14:0] exp_word, input logic [1:0] exp_cnt);
		start_decode(test, rx);
		finish_decode(test, exp_word, exp_cnt);
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================
	task automatic test_clean();
		logic [14:0] cw;
		for (int n = 0; n < n_clean; n++) begin
			cw = encode_message(7'($urandom()));
			run_decode($sformatf("clean %0d", n), cw, cw, 2'd0);
		end
	endtask

	task automatic test_single();
		logic [14:0] cw;
		logic [14:0] rx;
		for (int pos = 0; pos < 15; pos++) begin
			cw = encode_message(7'($urandom()));
			rx = cw ^ (15'd1 << pos);
			run_decode($sformatf("single pos %0d", pos), rx, cw, 2'd1);
		end
	endtask

	task automatic test_double();
		logic [14:0] cw;
		logic [14:0] rx;
		int p1;
		int p2;
		for (int n = 0; n < n_double; n++) begin
			cw = encode_message(7'($urandom()));
			p1 = int'($urandom() % 15);
			p2 = int'($urandom() % 15);
			while (p2 == p1)
				p2 = int'($urandom() % 15);
			rx = cw ^ (15'd1 << p1) ^ (15'd1 << p2);
			run_decode($sformatf("double %0d,%0d", p1, p2), rx, cw, 2'd2);
		end
	endtask

	// Three flips whose S1 sums to zero, so the word looks like no error to S1.
	task automatic test_uncorrectable();
		logic [14:0] cw;
		logic [14:0] pat;
		logic [14:0] rx;
		bit          found;
		found = 1'b0;
		pat   = '0;
		cw    = encode_message(7'($urandom()));
		for (int tries = 0; tries < 1000 && !found; tries++) begin
			pat = (15'd1 << ($urandom() % 15)) | (15'd1 << ($urandom() % 15)) |
				(15'd1 << ($urandom() % 15));
			found = (expected_count(pat) == 2'd3);
		end
		if (!found) begin
			$display("No error pattern with S1 zero and S3 nonzero was found");
			$display("FAIL: see errors above");
			$fatal(1, "Uncorrectable test could not run");
		end
		rx = cw ^ pat;
		run_decode("uncorrectable", rx, rx, 2'd3); // Word comes back as is.
	endtask

	task automatic test_protocol();
		logic [14:0] cw;
		logic [14:0] rx;
		logic [31:0] rd;
		logic        err;
		cw = encode_message(7'($urandom()));
		rx = cw ^ (15'd1 << 13);
		start_decode("protocol", rx);
		apb_write(bch_pkg::reg_ctrl, cmd_decode, err); // Search still running.
		check_value("protocol busy decode slverr", 32'd1, 32'(err));
		apb_read(4'h2, rd, err);
		check_value("protocol unmapped read slverr", 32'd1, 32'(err));
		apb_write(4'h6, 32'h0, err);
		check_value("protocol unmapped write slverr", 32'd1, 32'(err));
		finish_decode("protocol", cw, 2'd1);
		apb_read(bch_pkg::reg_status, rd, err);
		check_value("protocol done after clear", 32'd0, 32'(rd[1]));
	endtask

	initial begin
		clk     = 1'b0;
		arst_n  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		void'($urandom(32'hb3f1fb81));
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		test_clean();
		test_single();
		test_double();
		test_uncorrectable();
		test_protocol();
		$display("PASS: all tests");
		$finish;
	end

	// Budget of 40 cycles per test.
	initial begin
		repeat ((num_tests + 1) * 40) @(posedge clk);
		$display("Timeout after %0d cycles, decoder never reported done", (num_tests + 1) * 40);
		$display("FAIL: see errors above");
		$fatal(1, "Watchdog expired");
	end

endmodule
